// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

        ////////////////////////////////////////
        // major opcodes, inst[6:0]
        ////////////////////////////////////////
        localparam logic [6:0] op_r      = 7'b0110011; // reg-reg alu
        localparam logic [6:0] op_load   = 7'b0000011;
        localparam logic [6:0] op_jalr   = 7'b1100111;
        localparam logic [6:0] op_imm    = 7'b0010011; // reg-imm alu
        localparam logic [6:0] op_store  = 7'b0100011;
        localparam logic [6:0] op_branch = 7'b1100011;
        localparam logic [6:0] op_lui    = 7'b0110111;
        localparam logic [6:0] op_auipc  = 7'b0010111;
        localparam logic [6:0] op_jal    = 7'b1101111;

        // branch funct3
        localparam logic [2:0] f3_beq  = 3'b000;
        localparam logic [2:0] f3_bne  = 3'b001;
        localparam logic [2:0] f3_blt  = 3'b100;
        localparam logic [2:0] f3_bge  = 3'b101;
        localparam logic [2:0] f3_bltu = 3'b110;
        localparam logic [2:0] f3_bgeu = 3'b111;

        // load/store width, also the lsu access type
        localparam logic [2:0] f3_byte   = 3'b000;
        localparam logic [2:0] f3_half   = 3'b001;
        localparam logic [2:0] f3_word   = 3'b010;
        localparam logic [2:0] f3_byte_u = 3'b100; // loads only
        localparam logic [2:0] f3_half_u = 3'b101; // loads only

endpackage

// ==== rtl/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

        ////////////////////////////////////////
        // alu operation select
        ////////////////////////////////////////
        typedef enum logic [3:0] {
                add,    // also address and target adder
                sub,
                and_op,
                or_op,
                xor_op,
                sll,
                srl,
                sra,
                slt,    // signed compare
                sltu    // unsigned compare
        } alu_op_t;

        // write-back source for rd
        typedef enum logic [1:0] {
                wb_pc4, // link value of jal / jalr
                wb_alu,
                wb_imm, // lui
                wb_mem
        } wb_sel_t;

endpackage

// ==== rtl/decoder_control.sv ====
module decoder_control (
        input  logic [31:0]          inst,
        output logic [4:0]           rs1,
        output logic [4:0]           rs2,
        output logic [4:0]           rd,
        output logic signed [31:0]   imm,
        output rv_ctrl_pkg::alu_op_t alu_op,
        output logic                 alu_src_pc,
        output logic                 alu_src_imm,
        output logic                 mem_rd,
        output logic                 mem_wr,
        output logic [2:0]           mem_type,
        output logic                 reg_wr,
        output rv_ctrl_pkg::wb_sel_t wb_sel,
        output logic                 is_jump,
        output logic                 is_jalr,
        output logic                 beq,
        output logic                 bne,
        output logic                 blt,
        output logic                 bge,
        output logic                 bltu,
        output logic                 bgeu
);
        import rv_isa_pkg::*;
        import rv_ctrl_pkg::*;

        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        logic       cls_r, cls_load, cls_jalr, cls_imm, cls_store;
        logic       cls_branch, cls_lui, cls_auipc, cls_jal;
        logic       r_ok, imm_ok, load_ok, store_ok, jalr_ok;

        ////////////////////////////////////////
        // field split
        ////////////////////////////////////////
        assign opcode = inst[6:0];
        assign funct3 = inst[14:12];
        assign funct7 = inst[31:25];
        assign rs1    = inst[19:15];
        assign rs2    = inst[24:20];
        assign rd     = inst[11:7];

        // instruction class
        assign cls_r      = (opcode == op_r);
        assign cls_load   = (opcode == op_load);
        assign cls_jalr   = (opcode == op_jalr);
        assign cls_imm    = (opcode == op_imm);
        assign cls_store  = (opcode == op_store);
        assign cls_branch = (opcode == op_branch);
        assign cls_lui    = (opcode == op_lui);
        assign cls_auipc  = (opcode == op_auipc);
        assign cls_jal    = (opcode == op_jal);

        // legal funct3/funct7 combinations, the rest act as no-ops
        assign r_ok = cls_r && (funct7 == 7'h00 ||
                      (funct7 == 7'h20 && (funct3 == 3'h0 || funct3 == 3'h5)));
        assign imm_ok = cls_imm && ((funct3 != 3'h1 && funct3 != 3'h5) ||
                        funct7 == 7'h00 || (funct3 == 3'h5 && funct7 == 7'h20));
        assign load_ok = cls_load && (funct3 inside {f3_byte, f3_half, f3_word,
                                                     f3_byte_u, f3_half_u});
        assign store_ok = cls_store && (funct3 inside {f3_byte, f3_half, f3_word});
        assign jalr_ok  = cls_jalr && (funct3 == 3'b000);

        ////////////////////////////////////////
        // immediate generation
        ////////////////////////////////////////
        always_comb begin
                case (opcode)
                op_load, op_imm, op_jalr:
                        imm = {{20{inst[31]}}, inst[31:20]};
                op_store:
                        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                op_branch:
                        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                op_lui, op_auipc:
                        imm = {inst[31:12], 12'h000};
                op_jal:
                        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                default:
                        imm = '0;
                endcase
        end

        // strobes and selects
        assign mem_type    = funct3;
        assign mem_rd      = load_ok;
        assign mem_wr      = store_ok;
        assign reg_wr      = r_ok | imm_ok | load_ok | jalr_ok | cls_lui | cls_auipc | cls_jal;
        assign alu_src_pc  = cls_branch | cls_auipc | cls_jal; // pc + imm targets
        assign alu_src_imm = ~cls_r;
        assign is_jalr     = jalr_ok;
        assign is_jump     = cls_jal | jalr_ok;

        always_comb begin
                if (cls_jal || cls_jalr)
                        wb_sel = wb_pc4;
                else if (cls_lui)
                        wb_sel = wb_imm;
                else if (cls_load)
                        wb_sel = wb_mem;
                else
                        wb_sel = wb_alu;
        end

        // branch kind, one-hot or none
        assign beq  = cls_branch && (funct3 == f3_beq);
        assign bne  = cls_branch && (funct3 == f3_bne);
        assign blt  = cls_branch && (funct3 == f3_blt);
        assign bge  = cls_branch && (funct3 == f3_bge);
        assign bltu = cls_branch && (funct3 == f3_bltu);
        assign bgeu = cls_branch && (funct3 == f3_bgeu);

        ////////////////////////////////////////
        // alu operation
        ////////////////////////////////////////
        always_comb begin
                alu_op = add; // loads, stores, jumps, branches, auipc
                if (r_ok || imm_ok) begin
                        case (funct3)
                        3'h0:    alu_op = (cls_r && funct7[5]) ? sub : add;
                        3'h1:    alu_op = sll;
                        3'h2:    alu_op = slt;
                        3'h3:    alu_op = sltu;
                        3'h4:    alu_op = xor_op;
                        3'h5:    alu_op = funct7[5] ? sra : srl;
                        3'h6:    alu_op = or_op;
                        default: alu_op = and_op;
                        endcase
                end
        end

endmodule

// ==== rtl/alu.sv ====
module alu (
        input  logic [31:0]          a,
        input  logic [31:0]          b,
        input  rv_ctrl_pkg::alu_op_t op,
        output logic [31:0]          result
);
        import rv_ctrl_pkg::*;

        logic [4:0] shamt;

        assign shamt = b[4:0]; // only low five bits count in rv32

        always_comb begin
                case (op)
                add:
                        result = a + b;
                sub:
                        result = a - b;
                and_op:
                        result = a & b;
                or_op:
                        result = a | b;
                xor_op:
                        result = a ^ b;
                sll:
                        result = a << shamt;
                srl:
                        result = a >> shamt;
                sra:
                        result = $unsigned($signed(a) >>> shamt);
                slt:
                        result = {31'b0, $signed(a) < $signed(b)};
                sltu:
                        result = {31'b0, a < b};
                default:
                        result = a + b;
                endcase
        end

endmodule

// ==== rtl/branch_unit.sv ====
module branch_unit (
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic        beq,
        input  logic        bne,
        input  logic        blt,
        input  logic        bge,
        input  logic        bltu,
        input  logic        bgeu,
        output logic        taken
);
        logic eq, lt, ltu;

        // one comparison of each kind, shared by all strobes
        assign eq  = (a == b);
        assign lt  = ($signed(a) < $signed(b));
        assign ltu = (a < b);

        assign taken = (beq  &  eq)  | (bne  & ~eq)  |
                       (blt  &  lt)  | (bge  & ~lt)  |
                       (bltu &  ltu) | (bgeu & ~ltu); // low with no strobe

endmodule

// ==== rtl/reg_file.sv ====
module reg_file (
        input  logic        clk,
        input  logic        reset,
        input  logic [4:0]  rs1,
        input  logic [4:0]  rs2,
        input  logic [4:0]  rd,
        input  logic        wr_en,
        input  logic [31:0] wr_data,
        output logic [31:0] rs1_data,
        output logic [31:0] rs2_data
);
        logic [31:0] regs [1:31]; // x0 has no storage

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 1; i < 32; i++)
                                regs[i] <= '0;
                end else if (wr_en && rd != 5'd0) begin
                        regs[rd] <= wr_data;
                end
        end

        // async read, x0 reads zero
        assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
        assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// ==== rtl/load_store_unit.sv ====
module load_store_unit (
        input  logic [31:0] addr,
        input  logic [31:0] store_data,
        input  logic [2:0]  mem_type,
        input  logic        mem_rd,
        input  logic        mem_wr,
        output logic [31:0] dmem_addr,
        output logic [31:0] dmem_wdata,
        output logic [3:0]  dmem_be,
        output logic        dmem_rd,
        output logic        dmem_wr,
        input  logic [31:0] dmem_rdata,
        output logic [31:0] load_data
);
        import rv_isa_pkg::*;

        logic [7:0]  ld_byte;
        logic [15:0] ld_half;

        assign dmem_addr = {addr[31:2], 2'b00}; // low bits only pick the lane
        assign dmem_rd   = mem_rd;
        assign dmem_wr   = mem_wr;

        ////////////////////////////////////////
        // store lanes
        ////////////////////////////////////////
        always_comb begin
                case (mem_type)
                f3_byte: begin
                        dmem_wdata = {4{store_data[7:0]}};
                        dmem_be    = 4'b0001 << addr[1:0];
                end
                f3_half: begin
                        dmem_wdata = {2{store_data[15:0]}};
                        dmem_be    = addr[1] ? 4'b1100 : 4'b0011;
                end
                default: begin
                        dmem_wdata = store_data;
                        dmem_be    = 4'b1111;
                end
                endcase
                if (!mem_wr)
                        dmem_be = 4'b0000;
        end

        // load lane select and extension
        assign ld_byte = dmem_rdata[8 * addr[1:0] +: 8];
        assign ld_half = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

        always_comb begin
                case (mem_type)
                f3_byte:   load_data = {{24{ld_byte[7]}}, ld_byte};
                f3_byte_u: load_data = {24'd0, ld_byte};
                f3_half:   load_data = {{16{ld_half[15]}}, ld_half};
                f3_half_u: load_data = {16'd0, ld_half};
                default:   load_data = dmem_rdata; // lw
                endcase
        end

endmodule

// ==== rtl/rv_core.sv ====
module rv_core #(
        parameter logic [31:0] reset_vector = 32'h0000_0000
) (
        input  logic        clk,
        input  logic        reset,
        output logic [31:0] imem_addr,
        input  logic [31:0] imem_data,
        output logic [31:0] dmem_addr,
        output logic [31:0] dmem_wdata,
        output logic [3:0]  dmem_be,
        output logic        dmem_rd,
        output logic        dmem_wr,
        input  logic [31:0] dmem_rdata
);
        import rv_ctrl_pkg::*;

        logic [31:0]        pc, pc_plus4, next_pc;
        logic [4:0]         rs1, rs2, rd;
        logic signed [31:0] imm;
        alu_op_t            alu_op;
        wb_sel_t            wb_sel;
        logic               alu_src_pc, alu_src_imm;
        logic               mem_rd, mem_wr, reg_wr;
        logic [2:0]         mem_type;
        logic               is_jump, is_jalr, taken;
        logic               beq, bne, blt, bge, bltu, bgeu;
        logic [31:0]        rs1_data, rs2_data, alu_a, alu_b, alu_result;
        logic [31:0]        load_data, wb_data;

        ////////////////////////////////////////
        // pc and next-pc
        ////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (reset)
                        pc <= reset_vector;
                else
                        pc <= next_pc;
        end

        assign imem_addr = pc;
        assign pc_plus4  = pc + 32'd4;
        assign next_pc   = !(is_jump || taken) ? pc_plus4 :
                           is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

        decoder_control decoder_i (
                .inst(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
                .alu_op(alu_op), .alu_src_pc(alu_src_pc), .alu_src_imm(alu_src_imm),
                .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_type(mem_type), .reg_wr(reg_wr),
                .wb_sel(wb_sel), .is_jump(is_jump), .is_jalr(is_jalr),
                .beq(beq), .bne(bne), .blt(blt), .bge(bge), .bltu(bltu), .bgeu(bgeu)
        );

        reg_file reg_file_i (
                .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
                .wr_en(reg_wr & ~reset), .wr_data(wb_data), // no writes in reset
                .rs1_data(rs1_data), .rs2_data(rs2_data)
        );

        // operand muxes
        assign alu_a = alu_src_pc ? pc : rs1_data;
        assign alu_b = alu_src_imm ? imm : rs2_data;

        alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

        branch_unit branch_i (
                .a(rs1_data), .b(rs2_data), .beq(beq), .bne(bne), .blt(blt),
                .bge(bge), .bltu(bltu), .bgeu(bgeu), .taken(taken)
        );

        load_store_unit lsu_i (
                .addr(alu_result), .store_data(rs2_data), .mem_type(mem_type),
                .mem_rd(mem_rd & ~reset), .mem_wr(mem_wr & ~reset),
                .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
                .dmem_rd(dmem_rd), .dmem_wr(dmem_wr), .dmem_rdata(dmem_rdata),
                .load_data(load_data)
        );

        // write-back
        always_comb begin
                case (wb_sel)
                wb_pc4:  wb_data = pc_plus4;
                wb_imm:  wb_data = imm;
                wb_mem:  wb_data = load_data;
                default: wb_data = alu_result;
                endcase
        end

endmodule

// ==== verification/rv_core_assert.sv ====
module rv_core_assert #(
        parameter logic [31:0] reset_vector = 32'h0000_0000
) (
        input logic        clk,
        input logic        reset,
        input logic [31:0] imem_addr,
        input logic [31:0] dmem_addr,
        input logic [31:0] dmem_wdata,
        input logic [3:0]  dmem_be,
        input logic        dmem_rd,
        input logic        dmem_wr
);
        timeunit 1ns;
        timeprecision 100ps;

        int          fail_count = 0; // read by the testbench at the end
        logic [36:0] store_exp;      // {known, be, wdata}

        ////////////////////////////////////////
        // expected stores, x1 = 100, x2 = -7
        ////////////////////////////////////////
        function automatic logic [36:0] store_table(input logic [31:0] addr);
                case (addr)
                32'h000: return {1'b1, 4'hf, 32'h0000_0064}; // addi
                32'h004: return {1'b1, 4'hf, 32'h0000_006b}; // 100 - (-7)
                32'h008: return {1'b1, 4'hf, 32'hffff_ff9d}; // xor
                32'h00c: return {1'b1, 4'hf, 32'hffff_fffd}; // or
                32'h010: return {1'b1, 4'hf, 32'h0000_0060}; // and
                32'h014: return {1'b1, 4'hf, 32'hffff_ff90}; // -7 << 4
                32'h018: return {1'b1, 4'hf, 32'h0fff_ffff}; // logical >> 4
                32'h01c: return {1'b1, 4'hf, 32'hffff_ffff}; // arith >> 4
                32'h020: return {1'b1, 4'hf, 32'h0000_0001}; // -7 < 100 signed
                32'h024: return {1'b1, 4'hf, 32'h0000_0000}; // not below unsigned
                32'h028: return {1'b1, 4'hf, 32'habcd_e000}; // lui
                32'h02c: return {1'b1, 4'hf, 32'h0000_1060}; // auipc at pc 0x60
                32'h030: return {1'b1, 4'h1, 32'ha3a3_a3a3}; // sb, one lane each
                32'h034: return {1'b1, 4'h2, 32'ha3a3_a3a3};
                32'h038: return {1'b1, 4'h4, 32'ha3a3_a3a3};
                32'h03c: return {1'b1, 4'h8, 32'ha3a3_a3a3};
                32'h040: return {1'b1, 4'h3, 32'h05a3_05a3}; // sh low half
                32'h044: return {1'b1, 4'hc, 32'h05a3_05a3}; // sh high half
                32'h048: return {1'b1, 4'hf, 32'hffff_ffa3}; // lb sign-extended
                32'h04c: return {1'b1, 4'hf, 32'h0000_00a3}; // lbu
                32'h050: return {1'b1, 4'hf, 32'h0000_0000}; // x0 after a write
                32'h054: return {1'b1, 4'hf, 32'h0000_00e8}; // jal link
                32'h058: return {1'b1, 4'hf, 32'h0000_00f8}; // jalr link
                default: return '0; // trap slots land here
                endcase
        endfunction

        // control transfers, everything else falls through
        function automatic logic [31:0] next_pc_of(input logic [31:0] pc);
                case (pc)
                32'h0a0: return 32'h0a8; // beq taken
                32'h0ac: return 32'h0b4; // bne taken
                32'h0b8: return 32'h0c0; // blt taken
                32'h0c4: return 32'h0cc; // bge taken
                32'h0d0: return 32'h0d8; // bltu taken
                32'h0dc: return 32'h0e4; // bgeu taken
                32'h0e4: return 32'h0ec; // jal +8
                32'h0f4: return 32'h100; // jalr to 0x101, bit 0 cleared
                32'h104: return 32'h104; // final self-loop
                default: return pc + 32'd4;
                endcase
        endfunction

        assign store_exp = store_table(dmem_addr);

        ////////////////////////////////////////
        // checks
        ////////////////////////////////////////
        store_addr_known: assert property (@(posedge clk) disable iff (reset)
                dmem_wr |-> store_exp[36])
        else begin
                fail_count = fail_count + 1;
                $error("ERROR %0t: store to unexpected address %h", $time,
                       $sampled(dmem_addr));
        end

        store_value: assert property (@(posedge clk) disable iff (reset)
                dmem_wr && store_exp[36] |->
                        dmem_wdata == store_exp[31:0] && dmem_be == store_exp[35:32])
        else begin
                fail_count = fail_count + 1;
                $error("ERROR %0t: store at %h wrote %h be %b", $time, $sampled(dmem_addr),
                       $sampled(dmem_wdata), $sampled(dmem_be));
        end

        pc_flow: assert property (@(posedge clk) disable iff (reset)
                !reset |=> imem_addr == next_pc_of($past(imem_addr)))
        else begin
                fail_count = fail_count + 1;
                $error("ERROR %0t: pc went from %h to %h", $time, $past(imem_addr),
                       $sampled(imem_addr));
        end

        // held in reset: no memory strobes, pc parked
        reset_quiet: assert property (@(posedge clk)
                reset && $past(reset) |-> !dmem_wr && !dmem_rd && imem_addr == reset_vector)
        else begin
                fail_count = fail_count + 1;
                $error("ERROR %0t: core active during reset, pc %h", $time,
                       $sampled(imem_addr));
        end

endmodule

// ==== verification/rv_core_tb.sv ====
module rv_core_tb;
        timeunit 1ns;
        timeprecision 100ps;

        import rv_isa_pkg::*;

        localparam logic [31:0] halt_pc     = 32'h0000_0104;
        localparam int          cycle_limit = 200; // program runs about 60 cycles

        logic        clk;
        logic        reset;
        logic [31:0] imem_addr, imem_data;
        logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
        logic [3:0]  dmem_be;
        logic        dmem_rd, dmem_wr;
        logic [31:0] rom [0:127];
        logic [31:0] ram [0:63];
        logic [31:0] boot_inst;
        int          rom_ptr;
        int          cycles;
        int          errors;
        logic        timed_out;

        rv_core #(.reset_vector(32'h0000_0000)) dut_i (
                .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
                .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be),
                .dmem_rd(dmem_rd), .dmem_wr(dmem_wr), .dmem_rdata(dmem_rdata)
        );

        bind rv_core rv_core_assert #(.reset_vector(reset_vector)) assert_i (
                .clk(clk), .reset(reset), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
                .dmem_wdata(dmem_wdata), .dmem_be(dmem_be), .dmem_rd(dmem_rd),
                .dmem_wr(dmem_wr)
        );

        ////////////////////////////////////////
        // memories
        ////////////////////////////////////////
        assign imem_data  = rom[imem_addr[8:2]];
        assign dmem_rdata = dmem_rd ? ram[dmem_addr[7:2]] : 32'h0; // same-cycle read

        always @(posedge clk) begin
                if (dmem_wr) begin
                        for (int b = 0; b < 4; b++)
                                if (dmem_be[b])
                                        ram[dmem_addr[7:2]][8 * b +: 8] <= dmem_wdata[8 * b +: 8];
                end
        end

        // instruction formats
        function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [2:0] f3);
                return {f7, rs2, rs1, f3, rd, op_r};
        endfunction

        function automatic logic [31:0] i_type(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [11:0] imm);
                return {imm, rs1, f3, rd, op};
        endfunction

        function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [2:0] f3,
                                               input logic [11:0] imm);
                return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store}; // base is x0
        endfunction

        function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [2:0] f3, input logic [12:0] off);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
        endfunction

        function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [19:0] imm);
                return {imm, rd, op};
        endfunction

        function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
                return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
        endfunction

        task automatic emit(input logic [31:0] inst);
                rom[rom_ptr] = inst;
                rom_ptr++;
        endtask

        ////////////////////////////////////////
        // program, pc in the comments
        ////////////////////////////////////////
        task automatic load_program;
                logic [31:0] trap;
                trap = s_type(5'd0, f3_word, 12'h0f0); // wrong path marker
                for (int i = 0; i < 128; i++)
                        rom[i] = s_type(5'd0, f3_word, 12'h800 + 12'(i * 4)); // tagged by slot
                rom_ptr = 0;
                emit(i_type(op_imm, 5'd1, 5'd0, 3'h0, 12'd100));     // 00 x1 = 100
                emit(i_type(op_imm, 5'd2, 5'd0, 3'h0, 12'hff9));     // 04 x2 = -7
                emit(s_type(5'd1, f3_word, 12'h000));
                emit(r_type(7'h20, 5'd3, 5'd1, 5'd2, 3'h0));         // 0c sub
                emit(s_type(5'd3, f3_word, 12'h004));
                emit(r_type(7'h00, 5'd4, 5'd1, 5'd2, 3'h4));         // 14 xor
                emit(s_type(5'd4, f3_word, 12'h008));
                emit(r_type(7'h00, 5'd5, 5'd1, 5'd2, 3'h6));         // 1c or
                emit(s_type(5'd5, f3_word, 12'h00c));
                emit(r_type(7'h00, 5'd6, 5'd1, 5'd2, 3'h7));         // 24 and
                emit(s_type(5'd6, f3_word, 12'h010));
                emit(i_type(op_imm, 5'd7, 5'd0, 3'h0, 12'd4));       // 2c shift amount
                emit(r_type(7'h00, 5'd8, 5'd2, 5'd7, 3'h1));         // 30 sll
                emit(s_type(5'd8, f3_word, 12'h014));
                emit(r_type(7'h00, 5'd8, 5'd2, 5'd7, 3'h5));         // 38 srl
                emit(s_type(5'd8, f3_word, 12'h018));
                emit(r_type(7'h20, 5'd8, 5'd2, 5'd7, 3'h5));         // 40 sra
                emit(s_type(5'd8, f3_word, 12'h01c));
                emit(r_type(7'h00, 5'd8, 5'd2, 5'd1, 3'h2));         // 48 slt
                emit(s_type(5'd8, f3_word, 12'h020));
                emit(r_type(7'h00, 5'd8, 5'd2, 5'd1, 3'h3));         // 50 sltu
                emit(s_type(5'd8, f3_word, 12'h024));
                emit(u_type(op_lui, 5'd8, 20'habcde));               // 58
                emit(s_type(5'd8, f3_word, 12'h028));
                emit(u_type(op_auipc, 5'd8, 20'h00001));             // 60
                emit(s_type(5'd8, f3_word, 12'h02c));
                emit(i_type(op_imm, 5'd9, 5'd0, 3'h0, 12'h5a3));     // 68 lane pattern
                emit(s_type(5'd9, f3_byte, 12'h030));                // 6c sb, lanes 0..3
                emit(s_type(5'd9, f3_byte, 12'h035));
                emit(s_type(5'd9, f3_byte, 12'h03a));
                emit(s_type(5'd9, f3_byte, 12'h03f));
                emit(s_type(5'd9, f3_half, 12'h040));                // 7c sh
                emit(s_type(5'd9, f3_half, 12'h046));
                emit(i_type(op_load, 5'd10, 5'd0, f3_byte, 12'h03f));   // 84 lb 0xa3
                emit(i_type(op_load, 5'd11, 5'd0, f3_byte_u, 12'h03f)); // 88 lbu
                emit(s_type(5'd10, f3_word, 12'h048));
                emit(s_type(5'd11, f3_word, 12'h04c));
                emit(i_type(op_imm, 5'd0, 5'd0, 3'h0, 12'd5));       // 94 write x0
                emit(s_type(5'd0, f3_word, 12'h050));
                // each pair: not taken, then taken over the shared trap slot
                emit(b_type(5'd1, 5'd2, f3_beq, 13'd8));             // 9c
                emit(b_type(5'd1, 5'd1, f3_beq, 13'd8));
                emit(trap);
                emit(b_type(5'd1, 5'd1, f3_bne, 13'd8));             // a8
                emit(b_type(5'd1, 5'd2, f3_bne, 13'd8));
                emit(trap);
                emit(b_type(5'd1, 5'd2, f3_blt, 13'd8));             // b4
                emit(b_type(5'd2, 5'd1, f3_blt, 13'd8));
                emit(trap);
                emit(b_type(5'd2, 5'd1, f3_bge, 13'd8));             // c0
                emit(b_type(5'd1, 5'd2, f3_bge, 13'd8));
                emit(trap);
                emit(b_type(5'd2, 5'd1, f3_bltu, 13'd8));            // cc
                emit(b_type(5'd1, 5'd2, f3_bltu, 13'd8));
                emit(trap);
                emit(b_type(5'd1, 5'd2, f3_bgeu, 13'd8));            // d8
                emit(b_type(5'd2, 5'd1, f3_bgeu, 13'd8));
                emit(trap);
                emit(j_type(5'd12, 21'd8));                          // e4 jal
                emit(trap);
                emit(s_type(5'd12, f3_word, 12'h054));               // ec
                emit(i_type(op_imm, 5'd13, 5'd0, 3'h0, 12'h100));
                emit(i_type(op_jalr, 5'd14, 5'd13, 3'h0, 12'h001));  // f4 odd target
                emit(trap);
                emit(trap);
                emit(s_type(5'd14, f3_word, 12'h058));               // 100
                emit(j_type(5'd0, 21'd0));                           // 104 halt
        endtask

        task automatic fill_ram;
                for (int i = 0; i < 64; i++)
                        ram[i] = 32'hc0de_0000 + 32'(i * 4);
        endtask

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        ////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////
        initial begin
                reset  = 1'b1;
                cycles = 0;
                load_program();
                fill_ram();
                // a store, then a load, sit at the reset vector while reset is high
                boot_inst = rom[0];
                rom[0]    = s_type(5'd1, f3_word, 12'h0f0);
                repeat (8) @(posedge clk);
                #2;
                rom[0] = i_type(op_load, 5'd1, 5'd0, f3_word, 12'h0f0);
                repeat (8) @(posedge clk);
                #2;
                rom[0] = boot_inst;
                reset  = 1'b0;
                while (imem_addr !== halt_pc && cycles < cycle_limit) begin
                        @(posedge clk);
                        #2;
                        cycles++;
                end
                timed_out = (imem_addr !== halt_pc);
                if (timed_out) begin
                        $display("program never reached its final self-loop in %0d cycles",
                                 cycle_limit);
                end else begin
                        repeat (2) @(posedge clk); // let the last checks fire
                        #2;
                end
                errors = dut_i.assert_i.fail_count;
                $display("errors: %0d assertion failures, %0d timeouts", errors, timed_out);
                if (errors == 0 && !timed_out) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

// ==== rv_core.f ====
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/decoder_control.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/reg_file.sv
rtl/load_store_unit.sv
rtl/rv_core.sv
verification/rv_core_assert.sv
verification/rv_core_tb.sv

// ==== Makefile ====
SHELL      := /bin/bash

VERILATOR  ?= verilator
TOP        := rv_core_tb
FILELIST   := rv_core.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
